/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Instructions are always 32 bits wide, whatever the datapath width.
  localparam int unsigned ILEN = 32;

  // Major opcodes of RV32I, taken from inst[6:0].
  typedef enum logic [6:0] {
    OPC_LUI     = 7'b0110111,
    OPC_AUIPC   = 7'b0010111,
    OPC_JAL     = 7'b1101111,
    OPC_JALR    = 7'b1100111,
    OPC_BRANCH  = 7'b1100011,
    OPC_LOAD    = 7'b0000011,
    OPC_STORE   = 7'b0100011,
    OPC_OP_IMM  = 7'b0010011,
    OPC_OP      = 7'b0110011,
    OPC_SYSTEM  = 7'b1110011,
    OPC_FENCE_I = 7'b0001111
  } opcode_e;

  // ALU operation is {funct7[5], funct3}, so the decoder builds it directly
  // from the instruction bits.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  // Branch conditions by funct3. The codes 010 and 011 are unused.
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

endpackage

/* common/core_cfg_pkg.sv */
package core_cfg_pkg;

  import rv_isa_pkg::*;

  typedef logic [4:0] reg_idx_t;

  // Stage payloads for a datapath of XLEN bits.
  virtual class core_types #(parameter int unsigned XLEN = 32);

    typedef struct packed {
      logic [XLEN-1:0] op1;
      logic [XLEN-1:0] op2;
      logic [XLEN-1:0] jump_base;
      logic [XLEN-1:0] imm;
      alu_op_e         alu_op;
      reg_idx_t        rd;
      logic            rd_we;      // Format has a destination.
      logic            is_branch;
      logic            is_jump;
      logic            is_load;
      logic            is_store;
      logic            illegal;
      branch_f3_e      branch_f3;
      logic [XLEN-1:0] pc;
    } uop_t;

    typedef struct packed {
      logic [XLEN-1:0] rd_data;
      reg_idx_t        rd;
      logic            rd_we;      // Final write enable with x0 and non-writers removed.
      logic            jump_taken;
      logic [XLEN-1:0] target;
      logic [XLEN-1:0] mem_addr;
      logic            mem_rd;
      logic            mem_wr;
      logic            illegal;
    } result_t;

  endclass

endpackage

/* common/stage_if.sv */
`timescale 1ns/1ps

// Valid/ready link between two pipeline stages.
// A transfer happens on a clock edge where valid and ready are both high.
// Once valid rises, valid and data hold until that transfer.
interface stage_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  modport producer (
    output valid,
    output data,
    input  ready
  );

  modport consumer (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import core_cfg_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  reg_idx_t        rs1_i,
  input  reg_idx_t        rs2_i,
  output logic [XLEN-1:0] rdata1_o,
  output logic [XLEN-1:0] rdata2_o,
  input  logic            we_i,
  input  reg_idx_t        waddr_i,
  input  logic [XLEN-1:0] wdata_i
);

  logic [XLEN-1:0] regs [1:31];   // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // A write in the same cycle is forwarded to a reader of that register.
  function automatic logic [XLEN-1:0] read_port(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (we_i && (waddr_i == idx)) begin
      return wdata_i;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rdata1_o = read_port(rs1_i);
    rdata2_o = read_port(rs2_i);
  end

endmodule

/* decode/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid_i,
  input  logic [ILEN-1:0]  inst_i,
  input  logic [XLEN-1:0]  pc_i,
  output logic             in_ready_o,
  output reg_idx_t         rs1_o,
  output reg_idx_t         rs2_o,
  input  logic [XLEN-1:0]  rdata1_i,
  input  logic [XLEN-1:0]  rdata2_i,
  input  reg_idx_t         pend_rd_i,
  input  logic             pend_we_i,
  stage_if.producer        dec
);

  typedef core_types#(XLEN)::uop_t uop_t;

  logic [ILEN-1:0] inst_q;
  logic [XLEN-1:0] pc_q;
  logic            full_q;

  opcode_e   opcode;
  reg_idx_t  f_rd;
  reg_idx_t  f_rs1;
  reg_idx_t  f_rs2;
  logic [2:0] f_funct3;

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic            uses_rs1, uses_rs2;
  logic            hazard;
  uop_t            uop;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full_q <= 1'b1;
    end else if (dec.valid && dec.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign opcode   = opcode_e'(inst_q[6:0]);
  assign f_rd     = inst_q[11:7];
  assign f_funct3 = inst_q[14:12];
  assign f_rs1    = inst_q[19:15];
  assign f_rs2    = inst_q[24:20];

  // All immediates are sign extended from inst[31].
  assign imm_i = {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{(XLEN-12){inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{(XLEN-13){inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                  inst_q[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){inst_q[31]}}, inst_q[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                  inst_q[30:21], 1'b0};

  assign rs1_o = f_rs1;
  assign rs2_o = f_rs2;

  always_comb begin
    uop       = '0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    uop.pc    = pc_q;
    uop.rd    = f_rd;
    uop.alu_op = ALU_ADD;
    uop.branch_f3 = branch_f3_e'(f_funct3);
    case (opcode)
      OPC_LUI: begin
        uop.op2   = imm_u;   // op1 stays zero.
        uop.imm   = imm_u;
        uop.rd_we = 1'b1;
      end
      OPC_AUIPC: begin
        uop.op1   = pc_q;
        uop.op2   = imm_u;
        uop.imm   = imm_u;
        uop.rd_we = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // The ALU produces the link value pc + 4.
        uop.op1     = pc_q;
        uop.op2     = XLEN'(4);
        uop.rd_we   = 1'b1;
        uop.is_jump = 1'b1;
        if (opcode == OPC_JAL) begin
          uop.jump_base = pc_q;
          uop.imm       = imm_j;
        end else begin
          uop.jump_base = rdata1_i;
          uop.imm       = imm_i;
          uses_rs1      = 1'b1;
        end
      end
      OPC_BRANCH: begin
        uop.op1       = rdata1_i;
        uop.op2       = rdata2_i;
        uop.jump_base = pc_q;
        uop.imm       = imm_b;
        uop.is_branch = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
      end
      OPC_OP_IMM: begin
        uop.op1    = rdata1_i;
        uop.op2    = imm_i;
        uop.imm    = imm_i;
        uop.rd_we  = 1'b1;
        // Bit 30 selects SRAI and is plain immediate for the other funct3 codes.
        uop.alu_op = alu_op_e'({(f_funct3 == 3'b101) & inst_q[30], f_funct3});
        uses_rs1   = 1'b1;
      end
      OPC_OP: begin
        uop.op1    = rdata1_i;
        uop.op2    = rdata2_i;
        uop.rd_we  = 1'b1;
        uop.alu_op = alu_op_e'({inst_q[30], f_funct3});
        uses_rs1   = 1'b1;
        uses_rs2   = 1'b1;
      end
      OPC_LOAD: begin
        uop.op1     = rdata1_i;
        uop.op2     = imm_i;
        uop.imm     = imm_i;
        uop.rd_we   = 1'b1;
        uop.is_load = 1'b1;
        uses_rs1    = 1'b1;
      end
      OPC_STORE: begin
        uop.op1      = rdata1_i;
        uop.op2      = imm_s;
        uop.imm      = imm_s;
        uop.is_store = 1'b1;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;   // Store data waits for its producer too.
      end
      OPC_SYSTEM, OPC_FENCE_I: begin
      end
      default: begin
        uop.illegal = 1'b1;
      end
    endcase
  end

  // Hold the instruction back while execute owns an unwritten result it needs.
  assign hazard = pend_we_i && (pend_rd_i != '0) &&
                  ((uses_rs1 && (pend_rd_i == f_rs1)) ||
                   (uses_rs2 && (pend_rd_i == f_rs2)));

  assign dec.valid  = full_q && !hazard;
  assign dec.data   = uop;
  assign in_ready_o = !full_q || (dec.valid && dec.ready);

endmodule

/* execute/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic                          clk,
  input  logic                          rst,
  stage_if.consumer                     dec,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output core_types#(XLEN)::result_t    res_o,
  output reg_idx_t                      pend_rd_o,
  output logic                          pend_we_o,
  output logic                          wr_en_o,
  output reg_idx_t                      wr_addr_o,
  output logic [XLEN-1:0]               wr_data_o
);

  typedef core_types#(XLEN)::uop_t    uop_t;
  typedef core_types#(XLEN)::result_t result_t;

  localparam int unsigned SHW = $clog2(XLEN);

  uop_t            uop;
  result_t         res_d, res_q;
  logic            out_valid_q;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] jump_sum;
  logic [SHW-1:0]  shamt;
  logic            cond;
  logic            accept;

  assign uop   = dec.data;
  assign shamt = uop.op2[SHW-1:0];

  always_comb begin
    case (uop.alu_op)
      ALU_ADD:  alu_res = uop.op1 + uop.op2;
      ALU_SUB:  alu_res = uop.op1 - uop.op2;
      ALU_SLL:  alu_res = uop.op1 << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(uop.op1) < $signed(uop.op2)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, uop.op1 < uop.op2};
      ALU_XOR:  alu_res = uop.op1 ^ uop.op2;
      ALU_SRL:  alu_res = uop.op1 >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(uop.op1) >>> shamt);
      ALU_OR:   alu_res = uop.op1 | uop.op2;
      ALU_AND:  alu_res = uop.op1 & uop.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (uop.branch_f3)
      BEQ:     cond = (uop.op1 == uop.op2);
      BNE:     cond = (uop.op1 != uop.op2);
      BLT:     cond = ($signed(uop.op1) < $signed(uop.op2));
      BGE:     cond = ($signed(uop.op1) >= $signed(uop.op2));
      BLTU:    cond = (uop.op1 < uop.op2);
      BGEU:    cond = (uop.op1 >= uop.op2);
      default: cond = 1'b0;
    endcase
  end

  assign jump_sum = uop.jump_base + uop.imm;

  always_comb begin
    res_d            = '0;
    res_d.rd_data    = alu_res;
    res_d.rd         = uop.rd;
    res_d.rd_we      = uop.rd_we && !uop.is_load && !uop.is_store && !uop.is_branch &&
                       !uop.illegal && (uop.rd != '0);
    res_d.jump_taken = uop.is_jump || (uop.is_branch && cond);
    // Bit 0 is cleared for JALR; JAL and branch offsets are even anyway.
    res_d.target     = jump_sum & ~XLEN'(1);
    res_d.mem_rd     = uop.is_load;
    res_d.mem_wr     = uop.is_store;
    res_d.illegal    = uop.illegal;
    if (uop.is_load || uop.is_store) begin
      res_d.mem_addr = uop.op1 + uop.imm;
    end
  end

  // Take a new uop when the output is empty or leaves in this cycle.
  assign dec.ready = !out_valid_q || out_ready_i;
  assign accept    = dec.valid && dec.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_q <= res_d;
    end
  end

  assign out_valid_o = out_valid_q;
  assign res_o       = res_q;

  // The held result is what decode must wait for.
  assign pend_rd_o = res_q.rd;
  assign pend_we_o = out_valid_q && res_q.rd_we;

  // Write-back happens on retirement only.
  assign wr_en_o   = out_valid_q && out_ready_i && res_q.rd_we;
  assign wr_addr_o = res_q.rd;
  assign wr_data_o = res_q.rd_data;

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  input  logic [ILEN-1:0] inst_i,
  input  logic [XLEN-1:0] pc_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output reg_idx_t        rd_o,
  output logic            rd_we_o,
  output logic [XLEN-1:0] rd_data_o,
  output logic            jump_o,
  output logic [XLEN-1:0] target_o,
  output logic            mem_rd_o,
  output logic            mem_wr_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic            illegal_o
);

  typedef core_types#(XLEN)::uop_t    uop_t;
  typedef core_types#(XLEN)::result_t result_t;

  reg_idx_t        rs1, rs2;
  logic [XLEN-1:0] rdata1, rdata2;
  reg_idx_t        pend_rd;
  logic            pend_we;
  logic            wr_en;
  reg_idx_t        wr_addr;
  logic [XLEN-1:0] wr_data;
  result_t         res;

  stage_if #(.payload_t(uop_t)) dec_if ();

  inst_decode #(.XLEN(XLEN)) inst_decode_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .in_ready_o (in_ready_o),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rdata1_i   (rdata1),
    .rdata2_i   (rdata2),
    .pend_rd_i  (pend_rd),
    .pend_we_i  (pend_we),
    .dec        (dec_if.producer)
  );

  reg_file #(.XLEN(XLEN)) reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wr_en),
    .waddr_i  (wr_addr),
    .wdata_i  (wr_data)
  );

  exec_unit #(.XLEN(XLEN)) exec_unit_i (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec_if.consumer),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .res_o       (res),
    .pend_rd_o   (pend_rd),
    .pend_we_o   (pend_we),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data)
  );

  assign rd_o       = res.rd;
  assign rd_we_o    = res.rd_we;
  assign rd_data_o  = res.rd_data;
  assign jump_o     = res.jump_taken;
  assign target_o   = res.target;
  assign mem_rd_o   = res.mem_rd;
  assign mem_wr_o   = res.mem_wr;
  assign mem_addr_o = res.mem_addr;
  assign illegal_o  = res.illegal;

endmodule

/* test/rv_core_props.sv */
`timescale 1ns/1ps

module rv_core_props #(
  parameter int unsigned XLEN = 32
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 in_ready_i,
  input logic                 out_valid_i,
  input logic                 out_ready_i,
  input logic [3*XLEN+9:0]    result_i
);

  int fails = 0;   // Number of failed assertions so far.

  // A stalled result keeps its valid and every field until it is taken.
  property hold_while_stalled;
    @(posedge clk) disable iff (rst)
      (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(result_i));
  endproperty

  property empty_after_reset;
    @(posedge clk) rst |=> (!out_valid_i && in_ready_i);
  endproperty

  a_hold: assert property (hold_while_stalled)
    else begin
      fails++;
      $error("result changed or vanished while out_ready_i was low");
    end

  a_reset: assert property (empty_after_reset)
    else begin
      fails++;
      $error("core not empty and ready after a reset cycle");
    end

endmodule

bind rv_core_top rv_core_props #(.XLEN(XLEN)) rv_core_props_i (
  .clk         (clk),
  .rst         (rst),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    ({rd_o, rd_we_o, rd_data_o, jump_o, target_o,
                 mem_rd_o, mem_wr_o, mem_addr_o, illegal_o})
);

/* test/tb_types.svh */
`ifndef TB_TYPES_SVH
`define TB_TYPES_SVH

localparam int NUM_TESTS = 35;

// One table row holds the instruction, its pc and the result it must retire with.
typedef struct packed {
  logic [31:0] inst;
  logic [31:0] pc;
  logic [4:0]  rd;
  logic        rd_we;
  logic [31:0] rd_data;
  logic        jump;
  logic [31:0] target;
  logic        mem_rd;
  logic        mem_wr;
  logic [31:0] mem_addr;
  logic        illegal;
} tb_entry_t;

`endif

/* test/rv_core_checker.sv */
`timescale 1ns/1ps

`include "tb_types.svh"

module rv_core_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        out_valid_i,
  input  logic        out_ready_i,
  input  logic [4:0]  rd_i,
  input  logic        rd_we_i,
  input  logic [31:0] rd_data_i,
  input  logic        jump_i,
  input  logic [31:0] target_i,
  input  logic        mem_rd_i,
  input  logic        mem_wr_i,
  input  logic [31:0] mem_addr_i,
  input  logic        illegal_i,
  input  tb_entry_t   tbl_i [NUM_TESTS],
  output int          checked_o,
  output int          errors_o
);

  tb_entry_t expd;
  int        bad;

  task automatic compare_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
    if (want !== got) begin
      $display("** Error at %0t ns: test %0d %s expected %h got %h",
               $time, checked_o, name, want, got);
      bad++;
    end
  endtask

  // Each retirement is paired with the next row of the table.
  always @(posedge clk) begin
    if (rst) begin
      checked_o <= 0;
      errors_o  <= 0;
    end else if (out_valid_i && out_ready_i) begin
      if (checked_o >= NUM_TESTS) begin
        $display("Extra result retired at %0t ns after the last test", $time);
        errors_o <= errors_o + 1;
      end else begin
        expd = tbl_i[checked_o];
        bad  = 0;
        compare_field("rd_we", 32'(expd.rd_we), 32'(rd_we_i));
        compare_field("jump", 32'(expd.jump), 32'(jump_i));
        compare_field("mem_rd", 32'(expd.mem_rd), 32'(mem_rd_i));
        compare_field("mem_wr", 32'(expd.mem_wr), 32'(mem_wr_i));
        compare_field("illegal", 32'(expd.illegal), 32'(illegal_i));
        if (expd.rd_we) begin
          compare_field("rd", 32'(expd.rd), 32'(rd_i));
          compare_field("rd_data", expd.rd_data, rd_data_i);
        end
        if (expd.jump) begin
          compare_field("target", expd.target, target_i);
        end
        if (expd.mem_rd || expd.mem_wr) begin
          compare_field("mem_addr", expd.mem_addr, mem_addr_i);
        end
        if (bad == 0) begin
          $display("test %0d pc %h inst %h: ok", checked_o, expd.pc, expd.inst);
        end else begin
          $display("test %0d pc %h inst %h: %0d mismatches", checked_o, expd.pc,
                   expd.inst, bad);
        end
        errors_o  <= errors_o + bad;
        checked_o <= checked_o + 1;
      end
    end
  end

endmodule

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

`include "tb_types.svh"

module rv_core_tb;

  localparam int TIMEOUT = NUM_TESTS * 20;
  localparam logic [31:0] PC0 = 32'h100;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] SUB7       = 7'b0100000;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        in_ready_o;
  logic        out_valid_o;
  logic        out_ready_i;
  logic [4:0]  rd_o;
  logic        rd_we_o;
  logic [31:0] rd_data_o;
  logic        jump_o;
  logic [31:0] target_o;
  logic        mem_rd_o;
  logic        mem_wr_o;
  logic [31:0] mem_addr_o;
  logic        illegal_o;

  tb_entry_t tbl [NUM_TESTS];
  int        n_rows;
  int        checked;
  int        errors;
  int        cycles;
  integer    seed = 61590;

  rv_core_top #(.XLEN(32)) rv_core_top_i (.*);

  rv_core_checker checker_i (
    .clk (clk), .rst (rst), .out_valid_i (out_valid_o), .out_ready_i (out_ready_i),
    .rd_i (rd_o), .rd_we_i (rd_we_o), .rd_data_i (rd_data_o), .jump_i (jump_o),
    .target_i (target_o), .mem_rd_i (mem_rd_o), .mem_wr_i (mem_wr_o),
    .mem_addr_i (mem_addr_o), .illegal_i (illegal_o), .tbl_i (tbl),
    .checked_o (checked), .errors_o (errors)
  );

  // Instruction encoders for the RV32I base formats.
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_entry(input logic [31:0] inst, input logic [4:0] rd, input logic we,
      input logic [31:0] data, input logic jump, input logic [31:0] target,
      input logic mrd, input logic mwr, input logic [31:0] maddr, input logic ill);
    tbl[n_rows] = '{inst: inst, pc: PC0 + 32'(4 * n_rows), rd: rd, rd_we: we,
                    rd_data: data, jump: jump, target: target, mem_rd: mrd,
                    mem_wr: mwr, mem_addr: maddr, illegal: ill};
    n_rows++;
  endtask

  task automatic expect_write(input logic [31:0] inst, input logic [4:0] rd,
      input logic [31:0] data);
    add_entry(inst, rd, 1'b1, data, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic expect_branch(input logic [31:0] inst, input logic taken,
      input logic [31:0] target);
    add_entry(inst, '0, 1'b0, '0, taken, target, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic fill_table();
    n_rows = 0;
    expect_write({20'h12345, 5'd1, OPC_LUI}, 1, 32'h12345000);
    expect_write(i_type(12'h678, 1, 3'b000, 1, OPC_OP_IMM), 1, 32'h12345678);
    expect_write(i_type(12'hffb, 0, 3'b000, 2, OPC_OP_IMM), 2, 32'hfffffffb);
    expect_write(i_type(12'h003, 0, 3'b000, 3, OPC_OP_IMM), 3, 32'h3);
    expect_write(r_type(7'b0, 3, 1, 3'b000, 4), 4, 32'h1234567b);
    expect_write(r_type(SUB7, 2, 3, 3'b000, 5), 5, 32'h8);
    expect_write(r_type(7'b0, 3, 2, 3'b010, 6), 6, 32'h1);
    expect_write(r_type(7'b0, 3, 2, 3'b011, 7), 7, 32'h0);
    expect_write(r_type(7'b0, 2, 1, 3'b100, 8), 8, 32'hedcba983);
    expect_write(r_type(7'b0, 3, 1, 3'b110, 9), 9, 32'h1234567b);
    expect_write(r_type(7'b0, 2, 1, 3'b111, 10), 10, 32'h12345678);
    expect_write(r_type(7'b0, 3, 1, 3'b001, 11), 11, 32'h91a2b3c0);
    expect_write(r_type(7'b0, 3, 2, 3'b101, 12), 12, 32'h1fffffff);
    expect_write(r_type(SUB7, 3, 2, 3'b101, 13), 13, 32'hffffffff);
    expect_write(i_type(12'h401, 2, 3'b101, 14, OPC_OP_IMM), 14, 32'hfffffffd);
    expect_write({20'h00001, 5'd15, OPC_AUIPC}, 15, 32'h113c);
    add_entry(j_type(21'd8, 16), 16, 1'b1, 32'h144, 1'b1, 32'h148, 1'b0, 1'b0, '0, 1'b0);
    add_entry(i_type(12'h010, 3, 3'b000, 17, OPC_JALR), 17, 1'b1, 32'h148, 1'b1, 32'h12,
              1'b0, 1'b0, '0, 1'b0);
    expect_branch(b_type(13'd16, 3, 3, 3'b000), 1'b1, 32'h158);
    expect_branch(b_type(13'd16, 3, 3, 3'b001), 1'b0, '0);
    expect_branch(b_type(13'd16, 3, 2, 3'b100), 1'b1, 32'h160);
    expect_branch(b_type(13'd16, 3, 2, 3'b101), 1'b0, '0);
    expect_branch(b_type(13'd16, 3, 2, 3'b110), 1'b0, '0);
    expect_branch(b_type(13'd16, 3, 2, 3'b111), 1'b1, 32'h16c);
    add_entry(i_type(12'h008, 1, 3'b010, 3, OPC_LOAD), 3, 1'b0, '0, 1'b0, '0,
              1'b1, 1'b0, 32'h12345680, 1'b0);
    add_entry(s_type(12'hffc, 2, 1), 0, 1'b0, '0, 1'b0, '0, 1'b0, 1'b1, 32'h12345674, 1'b0);
    expect_write(r_type(7'b0, 0, 3, 3'b000, 18), 18, 32'h3);   // Load left x3 alone.
    // Undefined opcode whose rd field names x3, which a later ADDI reads.
    add_entry(32'h000001ff, 3, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
    add_entry(i_type(12'h007, 0, 3'b000, 0, OPC_OP_IMM), 0, 1'b0, '0, 1'b0, '0,
              1'b0, 1'b0, '0, 1'b0);
    expect_write(r_type(7'b0, 0, 0, 3'b000, 19), 19, 32'h0);
    add_entry(32'h00000073, 0, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
    expect_write(i_type(12'h001, 3, 3'b000, 20, OPC_OP_IMM), 20, 32'h4);
    expect_write(r_type(7'b0, 20, 20, 3'b000, 20), 20, 32'h8);
    expect_write(r_type(SUB7, 3, 20, 3'b000, 21), 21, 32'h5);
    expect_write(r_type(7'b0, 20, 21, 3'b100, 21), 21, 32'hd);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random back-pressure lowers ready on about a third of cycles.
  always @(negedge clk) begin
    out_ready_i = ($random(seed) % 3) != 0;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("Timeout after %0d cycles with %0d of %0d results", cycles, checked,
               NUM_TESTS);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    inst_i      = '0;
    pc_i        = '0;
    out_ready_i = 1'b0;
    cycles      = 0;
    fill_table();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      in_valid_i = 1'b1;
      inst_i     = tbl[i].inst;
      pc_i       = tbl[i].pc;
      @(posedge clk);
      while (!in_ready_o) @(posedge clk);
      @(negedge clk);
    end
    in_valid_i = 1'b0;
    wait (checked == NUM_TESTS);
    repeat (4) @(posedge clk);   // Room for a stray extra result to show up.
    $display("%0d of %0d tests checked, %0d errors, %0d assertion failures", checked,
             NUM_TESTS, errors, rv_core_top_i.rv_core_props_i.fails);
    if (errors == 0 && checked == NUM_TESTS &&
        rv_core_top_i.rv_core_props_i.fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+test
common/rv_isa_pkg.sv
common/core_cfg_pkg.sv
common/stage_if.sv
logic/reg_file.sv
decode/inst_decode.sv
execute/exec_unit.sv
logic/rv_core_top.sv
test/rv_core_props.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

/* Makefile */
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module rv_core_tb -o rv_core_sim
	./obj_dir/rv_core_sim | tee $(SIM_LOG)
	grep -qx "STATUS: PASS" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
